//--- run_sim.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_gpu -o tb_gpu_sim \
	&& ./obj_dir/tb_gpu_sim > sim.log 2>&1 \
	|| echo "STATUS: FAIL" >> sim.log
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1 || exit 0

//--- sim/gpu_chk.sv
`timescale 1ns/1ps
`default_nettype none
`include "gpu_params.svh"

module gpu_chk import gpu_pkg::*; (
	input wire logic rast_done,
	input wire logic rst_n,
	input wire logic mem_write,
	input wire logic mem_waitrequest,
	input wire logic [`GPU_PIX_BITS-1:0] mem_address,
	input wire logic [31:0] mem_writedata,
	input gpu_mode_t mode,
	input wire logic go,
	input wire logic frame_done
);

	// Set by a start, cleared once done is seen
	logic armed;

	always_ff @(posedge rast_done or negedge rst_n) begin
		if (!rst_n)
			armed <= 1'b0;
		else if (go)
			armed <= 1'b1;
		else if (frame_done)
			armed <= 1'b0;
	end

	a_write_held: assert property (@(posedge rast_done) disable iff (!rst_n)
		mem_write && mem_waitrequest |=>
			mem_write && $stable(mem_address) && $stable(mem_writedata))
		else $error("Memory write changed while waitrequest was high");

	a_no_write_clear_depth: assert property (@(posedge rast_done) disable iff (!rst_n)
		(mode == MODE_CLEAR_DEPTH) |-> !mem_write)
		else $error("Memory write issued in clear depth mode");

	a_done_after_start: assert property (@(posedge rast_done) disable iff (!rst_n)
		$rose(frame_done) |-> armed)
		else $error("frame_done rose without a start");

endmodule

bind gpu_core gpu_chk i_gpu_chk (
	.rast_done(rast_done),
	.rst_n(rst_n),
	.mem_write(mem_write),
	.mem_waitrequest(mem_waitrequest),
	.mem_address(mem_address),
	.mem_writedata(mem_writedata),
	.mode(mode),
	.go(go),
	.frame_done(frame_done)
);

`default_nettype wire

//--- sim/gpu_monitor.sv
`timescale 1ns/1ps
`default_nettype none
`include "gpu_params.svh"

module gpu_monitor (
	input wire logic rast_done,
	input wire logic rst_n,
	input wire logic mem_write,
	input wire logic mem_waitrequest,
	input wire logic [`GPU_PIX_BITS-1:0] mem_address,
	input wire logic [31:0] mem_writedata,
	input wire logic [31:0] reg_readdata,
	input wire logic frame_done
);

	localparam int PIXELS = `GPU_SCREEN_W * `GPU_SCREEN_H;

	// Frame memory as seen through accepted writes
	logic [31:0] image [PIXELS];
	logic run_seen [PIXELS];
	int error_count = 0;
	int test_errors = 0;
	int test_writes = 0;
	int test_num = 0;
	int tests_run = 0;
	int tests_failed = 0;

	task automatic flag_failure(input string msg);
		$display("%s", msg);
		error_count++;
		test_errors++;
	endtask

	task automatic mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("Mismatch at %0d ns: %s expected %h got %h", $time, name, expected, actual);
		error_count++;
		test_errors++;
	endtask

	// Accepted write needs strobe high and no waitrequest
	always @(posedge rast_done) begin
		if (rst_n && mem_write && !mem_waitrequest) begin
			if (run_seen[mem_address] === 1'b1)
				flag_failure($sformatf("Pixel %0d written twice in one run at %0d ns",
					mem_address, $time));
			run_seen[mem_address] = 1'b1;
			image[mem_address] = mem_writedata;
			test_writes++;
		end
	end

	task automatic begin_test(input int num);
		test_num = num;
		test_errors = 0;
		test_writes = 0;
	endtask

	task automatic begin_run();
		for (int i = 0; i < PIXELS; i++)
			run_seen[i] = 1'b0;
	endtask

	task automatic check_read(input logic [3:0] addr, input logic [31:0] expected);
		if (reg_readdata !== expected)
			mismatch($sformatf("reg_readdata[reg %0d]", addr), expected, reg_readdata);
	endtask

	task automatic check_probe(input logic [7:0] idx, input logic [31:0] expected);
		if (image[idx] !== expected)
			mismatch($sformatf("mem_writedata[pixel %0d]", idx), expected, image[idx]);
	endtask

	task automatic check_count(input int expected);
		if (test_writes != expected)
			mismatch("write count", expected, test_writes);
	endtask

	task automatic check_idle();
		if (mem_write !== 1'b0)
			mismatch("mem_write", 32'd0, {31'd0, mem_write});
		if (frame_done !== 1'b0)
			mismatch("frame_done", 32'd0, {31'd0, frame_done});
	endtask

	task automatic end_test();
		tests_run++;
		if (test_errors == 0) begin
			$display("Test %0d passed, %0d writes", test_num, test_writes);
		end else begin
			tests_failed++;
			$display("Test %0d failed with %0d errors", test_num, test_errors);
		end
	endtask

	task automatic report_totals();
		$display("Tests run %0d, passed %0d, failed %0d, errors %0d",
			tests_run, tests_run - tests_failed, tests_failed, error_count);
	endtask

endmodule

`default_nettype wire

//--- sim/gpu_stimulus.txt
# op a b ...  W reg data | R reg expect | V x0 y0 x1 y1 x2 y2 depth color | G mode
# P pixel expect | C writes in test | Q waitreq | I idle | T test | E end; all hex
T 1
I
R 0 0
C 0
E
T 2
W 3 00112233
G 2
R 0 1
W 0 0
R 0 0
C 100
P 0 00112233
P 7a 00112233
P ff 00112233
E
T 3
W 3 7fffffff
G 3
V 0 0 8 0 0 8 64 00ff0000
G 1
C 24
P 0 00ff0000
P 7 00ff0000
P 8 00112233
P 70 00ff0000
P 34 00ff0000
P 44 00112233
E
T 4
V 2 2 a 2 2 a 32 0000ff00
G 1
C 24
V 0 0 8 0 0 8 4b 000000ff
G 1
C 3e
P 22 0000ff00
P 25 0000ff00
P 0 000000ff
P 70 000000ff
P 29 0000ff00
P 44 0000ff00
E
T 5
W 3 7fffffff
G 3
C 0
G 1
C 24
P 22 000000ff
P 25 000000ff
P 0 000000ff
P 44 0000ff00
E
T 6
Q 1
W 3 00112233
G 2
W 3 7fffffff
G 3
V 0 0 8 0 0 8 64 00ff0000
G 1
Q 0
C 124
P 0 00ff0000
P 7 00ff0000
P 8 00112233
P 70 00ff0000
P 34 00ff0000
P 44 00112233
P 22 00ff0000
P 29 00112233
E

//--- sim/tb_gpu.sv
`timescale 1ns/1ps
`default_nettype none
`include "gpu_params.svh"

module tb_gpu;

	localparam int CLK_NS = 8;
	localparam int NUM_TESTS = 6;
	localparam int RUN_CYCLES = 4 * `GPU_SCREEN_W * `GPU_SCREEN_H;
	localparam int WATCHDOG_NS = NUM_TESTS * RUN_CYCLES * CLK_NS;

	logic rast_done;
	logic rst_n;
	logic reg_write;
	logic reg_read;
	logic [`GPU_REG_ADDR_BITS-1:0] reg_address;
	logic [31:0] reg_writedata;
	logic [31:0] reg_readdata;
	logic mem_write;
	logic [`GPU_PIX_BITS-1:0] mem_address;
	logic [31:0] mem_writedata;
	logic mem_waitrequest;
	logic frame_done;
	logic wait_en;
	integer seed = 93027;
	logic [31:0] field [8];

	gpu_core i_gpu_core (
		.rast_done(rast_done),
		.rst_n(rst_n),
		.reg_write(reg_write),
		.reg_read(reg_read),
		.reg_address(reg_address),
		.reg_writedata(reg_writedata),
		.reg_readdata(reg_readdata),
		.mem_write(mem_write),
		.mem_address(mem_address),
		.mem_writedata(mem_writedata),
		.mem_waitrequest(mem_waitrequest),
		.frame_done(frame_done)
	);

	gpu_monitor i_gpu_monitor (
		.rast_done(rast_done),
		.rst_n(rst_n),
		.mem_write(mem_write),
		.mem_waitrequest(mem_waitrequest),
		.mem_address(mem_address),
		.mem_writedata(mem_writedata),
		.reg_readdata(reg_readdata),
		.frame_done(frame_done)
	);

	initial begin
		rast_done = 1'b0;
		forever #(CLK_NS / 2) rast_done = ~rast_done;
	end

	// Random memory backpressure of about one cycle in four when enabled
	initial begin
		mem_waitrequest = 1'b0;
		forever begin
			@(posedge rast_done);
			#1;
			mem_waitrequest = wait_en && (($random(seed) & 3) == 0);
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Simulation timed out after %0d ns", WATCHDOG_NS);
		$display("STATUS: FAIL");
		$finish;
	end

	task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
		@(posedge rast_done);
		#1;
		reg_write = 1'b1;
		reg_address = addr;
		reg_writedata = data;
		@(posedge rast_done);
		#1;
		reg_write = 1'b0;
	endtask

	task automatic read_reg(input logic [3:0] addr, input logic [31:0] expected);
		@(posedge rast_done);
		#1;
		reg_read = 1'b1;
		reg_address = addr;
		@(negedge rast_done);
		i_gpu_monitor.check_read(addr, expected);
		@(posedge rast_done);
		#1;
		reg_read = 1'b0;
	endtask

	task automatic load_triangle();
		write_reg(`GPU_REG_X0, field[0]);
		write_reg(`GPU_REG_Y0, field[1]);
		write_reg(`GPU_REG_X1, field[2]);
		write_reg(`GPU_REG_Y1, field[3]);
		write_reg(`GPU_REG_X2, field[4]);
		write_reg(`GPU_REG_Y2, field[5]);
		write_reg(`GPU_REG_DEPTH, field[6]);
		write_reg(`GPU_REG_COLOR, field[7]);
	endtask

	// Clear done, pick the mode, start and wait for the frame
	task automatic run_mode(input logic [1:0] m);
		int cycles;
		write_reg(`GPU_REG_STATUS, 32'd0);
		write_reg(`GPU_REG_MODE, {30'd0, m});
		i_gpu_monitor.begin_run();
		write_reg(`GPU_REG_START, 32'd1);
		cycles = 0;
		while (!frame_done && cycles < RUN_CYCLES) begin
			@(negedge rast_done);
			cycles++;
		end
		if (!frame_done)
			i_gpu_monitor.flag_failure($sformatf(
				"Run in mode %0d did not finish within %0d cycles", m, RUN_CYCLES));
	endtask

	initial begin
		int fd;
		int rc;
		string line;
		logic [7:0] op;
		reg_write = 1'b0;
		reg_read = 1'b0;
		reg_address = '0;
		reg_writedata = '0;
		wait_en = 1'b0;
		rst_n = 1'b0;
		repeat (4) @(posedge rast_done);
		#1;
		rst_n = 1'b1;
		fd = $fopen("sim/gpu_stimulus.txt", "r");
		if (fd == 0) begin
			i_gpu_monitor.flag_failure("Could not open sim/gpu_stimulus.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				rc = $fgets(line, fd);
				op = 8'h00;
				if (rc > 0)
					rc = $sscanf(line, "%c %h %h %h %h %h %h %h %h", op, field[0], field[1],
						field[2], field[3], field[4], field[5], field[6], field[7]);
				case (op)
					"T": i_gpu_monitor.begin_test(field[0]);
					"E": i_gpu_monitor.end_test();
					"W": write_reg(field[0][3:0], field[1]);
					"R": read_reg(field[0][3:0], field[1]);
					"V": load_triangle();
					"G": run_mode(field[0][1:0]);
					"Q": wait_en = field[0][0];
					"P": begin
						@(negedge rast_done);
						i_gpu_monitor.check_probe(field[0][7:0], field[1]);
					end
					"C": begin
						@(negedge rast_done);
						i_gpu_monitor.check_count(field[0]);
					end
					"I": begin
						@(negedge rast_done);
						i_gpu_monitor.check_idle();
					end
					default: ;
				endcase
			end
			$fclose(fd);
		end
		if (i_gpu_monitor.tests_run != NUM_TESTS)
			i_gpu_monitor.flag_failure($sformatf("Ran %0d tests instead of %0d",
				i_gpu_monitor.tests_run, NUM_TESTS));
		i_gpu_monitor.report_totals();
		if (i_gpu_monitor.error_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- src/depth_test.sv
`timescale 1ns/1ps
`default_nettype none
`include "gpu_params.svh"

module depth_test import gpu_pkg::*; (
	input wire logic rast_done,
	input wire logic rst_n,
	input wire logic stall,
	input gpu_mode_t mode,
	input wire logic pix_valid,
	input wire logic [`GPU_PIX_BITS-1:0] pix_index,
	input pixel_word_u clear_word,
	input wire logic signed [31:0] tri_depth,
	input wire logic commit,
	input wire logic [`GPU_PIX_BITS-1:0] commit_index,
	output logic closer
);

	localparam int ENTRIES = `GPU_SCREEN_W * `GPU_SCREEN_H;

	logic signed [31:0] depth_mem [ENTRIES];
	logic signed [31:0] stored;

	assign stored = depth_mem[pix_index];

	// Single write port, clear walk or render commit
	always_ff @(posedge rast_done) begin
		if (mode == MODE_CLEAR_DEPTH && pix_valid && !stall)
			depth_mem[pix_index] <= clear_word.depth;
		else if (commit)
			depth_mem[commit_index] <= tri_depth;
	end

	// Smaller depth is nearer
	always_ff @(posedge rast_done or negedge rst_n) begin
		if (!rst_n)
			closer <= 1'b0;
		else if (!stall)
			closer <= (mode == MODE_RENDER) && (tri_depth < stored);
	end

endmodule

`default_nettype wire

//--- src/edge_eval.sv
`timescale 1ns/1ps
`default_nettype none
`include "gpu_params.svh"

module edge_eval (
	input wire logic rast_done,
	input wire logic rst_n,
	input wire logic stall,
	input wire logic [`GPU_COORD_BITS-1:0] pix_x,
	input wire logic [`GPU_COORD_BITS-1:0] pix_y,
	input wire logic [`GPU_COORD_BITS-1:0] x0,
	input wire logic [`GPU_COORD_BITS-1:0] y0,
	input wire logic [`GPU_COORD_BITS-1:0] x1,
	input wire logic [`GPU_COORD_BITS-1:0] y1,
	input wire logic [`GPU_COORD_BITS-1:0] x2,
	input wire logic [`GPU_COORD_BITS-1:0] y2,
	output logic covered
);

	// All coordinates doubled so the pixel center lands on an integer
	localparam int CW = `GPU_COORD_BITS + 4;
	localparam int EW = 2 * CW;

	logic signed [CW-1:0] cx, cy;
	logic signed [CW-1:0] ax, ay, bx, by, dx, dy;
	logic signed [EW-1:0] e0, e1, e2;

	function automatic logic signed [EW-1:0] edge_fn(
		input logic signed [CW-1:0] pax,
		input logic signed [CW-1:0] pay,
		input logic signed [CW-1:0] pbx,
		input logic signed [CW-1:0] pby,
		input logic signed [CW-1:0] ppx,
		input logic signed [CW-1:0] ppy
	);
		logic signed [EW-1:0] lhs;
		logic signed [EW-1:0] rhs;
		lhs = (pbx - pax) * (ppy - pay);
		rhs = (pby - pay) * (ppx - pax);
		return lhs - rhs;
	endfunction

	always_comb begin
		cx = signed'({3'b000, pix_x, 1'b1});
		cy = signed'({3'b000, pix_y, 1'b1});
		ax = signed'({3'b000, x0, 1'b0});
		ay = signed'({3'b000, y0, 1'b0});
		bx = signed'({3'b000, x1, 1'b0});
		by = signed'({3'b000, y1, 1'b0});
		dx = signed'({3'b000, x2, 1'b0});
		dy = signed'({3'b000, y2, 1'b0});
		e0 = edge_fn(ax, ay, bx, by, cx, cy);
		e1 = edge_fn(bx, by, dx, dy, cx, cy);
		e2 = edge_fn(dx, dy, ax, ay, cx, cy);
	end

	// Counter-clockwise with y taken as up, edges inclusive
	always_ff @(posedge rast_done or negedge rst_n) begin
		if (!rst_n)
			covered <= 1'b0;
		else if (!stall)
			covered <= (e0 >= 0) && (e1 >= 0) && (e2 >= 0);
	end

endmodule

`default_nettype wire

//--- src/gpu_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "gpu_params.svh"

module gpu_core import gpu_pkg::*; (
	input wire logic rast_done,
	input wire logic rst_n,
	input wire logic reg_write,
	input wire logic reg_read,
	input wire logic [`GPU_REG_ADDR_BITS-1:0] reg_address,
	input wire logic [31:0] reg_writedata,
	output logic [31:0] reg_readdata,
	output logic mem_write,
	output logic [`GPU_PIX_BITS-1:0] mem_address,
	output logic [31:0] mem_writedata,
	input wire logic mem_waitrequest,
	output logic frame_done
);

	logic go, finish, stall;
	gpu_mode_t mode;
	pixel_word_u clear_word, tri_color;
	logic [`GPU_COORD_BITS-1:0] x0, y0, x1, y1, x2, y2;
	logic signed [31:0] tri_depth;

	// Stage 0 and stage 1 of the pixel pipeline
	logic pix_valid, st1_valid;
	logic [`GPU_COORD_BITS-1:0] pix_x, pix_y;
	logic [`GPU_PIX_BITS-1:0] pix_index, st1_index;
	logic covered, closer;
	logic commit;
	logic [`GPU_PIX_BITS-1:0] commit_index;

	gpu_regs i_gpu_regs (
		.rast_done, .rst_n,
		.reg_write, .reg_read, .reg_address, .reg_writedata, .reg_readdata,
		.go, .mode, .clear_word,
		.x0, .y0, .x1, .y1, .x2, .y2,
		.tri_depth, .tri_color, .finish, .frame_done
	);

	raster_sequencer i_raster_sequencer (
		.rast_done, .rst_n, .go, .stall,
		.pix_valid, .pix_x, .pix_y, .pix_index,
		.st1_valid, .st1_index, .finish
	);

	edge_eval i_edge_eval (
		.rast_done, .rst_n, .stall, .pix_x, .pix_y,
		.x0, .y0, .x1, .y1, .x2, .y2, .covered
	);

	depth_test i_depth_test (
		.rast_done, .rst_n, .stall, .mode, .pix_valid, .pix_index,
		.clear_word, .tri_depth, .commit, .commit_index, .closer
	);

	pixel_writer i_pixel_writer (
		.rast_done, .rst_n, .mode, .st1_valid, .st1_index,
		.covered, .closer, .clear_word, .tri_color, .mem_waitrequest,
		.mem_write, .mem_address, .mem_writedata,
		.stall, .commit, .commit_index
	);

endmodule

`default_nettype wire

//--- src/gpu_params.svh
`ifndef GPU_PARAMS_SVH
`define GPU_PARAMS_SVH

// Screen geometry
`define GPU_SCREEN_W 16
`define GPU_SCREEN_H 16

// Pixel index, also the memory word address
`define GPU_PIX_BITS 8

// Unsigned vertex coordinate
`define GPU_COORD_BITS 8

// Host register map
`define GPU_REG_ADDR_BITS 4
`define GPU_REG_STATUS 4'd0
`define GPU_REG_START 4'd1
`define GPU_REG_MODE 4'd2
`define GPU_REG_CLEAR 4'd3
`define GPU_REG_X0 4'd4
`define GPU_REG_Y0 4'd5
`define GPU_REG_X1 4'd6
`define GPU_REG_Y1 4'd7
`define GPU_REG_X2 4'd8
`define GPU_REG_Y2 4'd9
`define GPU_REG_DEPTH 4'd10
`define GPU_REG_COLOR 4'd11

`endif

//--- src/gpu_pkg.sv
`default_nettype none

package gpu_pkg;

	typedef enum logic [1:0] {
		MODE_IDLE = 2'd0,
		MODE_RENDER = 2'd1,
		MODE_CLEAR_FRAME = 2'd2,
		MODE_CLEAR_DEPTH = 2'd3
	} gpu_mode_t;

	// One pixel word, seen as a color or as a depth
	typedef union packed {
		struct packed {
			logic [7:0] pad;
			logic [7:0] red;
			logic [7:0] green;
			logic [7:0] blue;
		} color;
		logic signed [31:0] depth;
	} pixel_word_u;

endpackage

`default_nettype wire

//--- src/gpu_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "gpu_params.svh"

module gpu_regs import gpu_pkg::*; (
	input wire logic rast_done,
	input wire logic rst_n,
	input wire logic reg_write,
	input wire logic reg_read,
	input wire logic [`GPU_REG_ADDR_BITS-1:0] reg_address,
	input wire logic [31:0] reg_writedata,
	output logic [31:0] reg_readdata,
	output logic go,
	output gpu_mode_t mode,
	output pixel_word_u clear_word,
	output logic [`GPU_COORD_BITS-1:0] x0,
	output logic [`GPU_COORD_BITS-1:0] y0,
	output logic [`GPU_COORD_BITS-1:0] x1,
	output logic [`GPU_COORD_BITS-1:0] y1,
	output logic [`GPU_COORD_BITS-1:0] x2,
	output logic [`GPU_COORD_BITS-1:0] y2,
	output logic signed [31:0] tri_depth,
	output pixel_word_u tri_color,
	input wire logic finish,
	output logic frame_done
);

	logic busy;
	logic done;
	logic start_val;

	always_ff @(posedge rast_done or negedge rst_n) begin
		if (!rst_n) begin
			go <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
			start_val <= 1'b0;
			mode <= MODE_IDLE;
			clear_word <= '0;
			x0 <= '0;
			y0 <= '0;
			x1 <= '0;
			y1 <= '0;
			x2 <= '0;
			y2 <= '0;
			tri_depth <= '0;
			tri_color <= '0;
		end else begin
			go <= 1'b0;
			if (reg_write) begin
				case (reg_address)
					`GPU_REG_STATUS: begin
						if (!reg_writedata[0])
							done <= 1'b0;
					end
					`GPU_REG_START: begin
						start_val <= reg_writedata[0];
						// A second start during a run is dropped
						if (reg_writedata[0] && !busy) begin
							go <= 1'b1;
							busy <= 1'b1;
						end
					end
					`GPU_REG_MODE: mode <= gpu_mode_t'(reg_writedata[1:0]);
					`GPU_REG_CLEAR: clear_word <= reg_writedata;
					`GPU_REG_X0: x0 <= reg_writedata[`GPU_COORD_BITS-1:0];
					`GPU_REG_Y0: y0 <= reg_writedata[`GPU_COORD_BITS-1:0];
					`GPU_REG_X1: x1 <= reg_writedata[`GPU_COORD_BITS-1:0];
					`GPU_REG_Y1: y1 <= reg_writedata[`GPU_COORD_BITS-1:0];
					`GPU_REG_X2: x2 <= reg_writedata[`GPU_COORD_BITS-1:0];
					`GPU_REG_Y2: y2 <= reg_writedata[`GPU_COORD_BITS-1:0];
					`GPU_REG_DEPTH: tri_depth <= reg_writedata;
					`GPU_REG_COLOR: tri_color <= reg_writedata;
					default: ;
				endcase
			end
			// Last pixel retired
			if (finish) begin
				busy <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	always_comb begin
		reg_readdata = '0;
		if (reg_read) begin
			case (reg_address)
				`GPU_REG_STATUS: reg_readdata = {30'b0, busy, done};
				`GPU_REG_START: reg_readdata = {31'b0, start_val};
				`GPU_REG_MODE: reg_readdata = {30'b0, mode};
				`GPU_REG_CLEAR: reg_readdata = clear_word;
				`GPU_REG_X0: reg_readdata = 32'(x0);
				`GPU_REG_Y0: reg_readdata = 32'(y0);
				`GPU_REG_X1: reg_readdata = 32'(x1);
				`GPU_REG_Y1: reg_readdata = 32'(y1);
				`GPU_REG_X2: reg_readdata = 32'(x2);
				`GPU_REG_Y2: reg_readdata = 32'(y2);
				`GPU_REG_DEPTH: reg_readdata = tri_depth;
				`GPU_REG_COLOR: reg_readdata = tri_color;
				default: reg_readdata = '0;
			endcase
		end
	end

	assign frame_done = done;

endmodule

`default_nettype wire

//--- src/pixel_writer.sv
`timescale 1ns/1ps
`default_nettype none
`include "gpu_params.svh"

module pixel_writer import gpu_pkg::*; (
	input wire logic rast_done,
	input wire logic rst_n,
	input gpu_mode_t mode,
	input wire logic st1_valid,
	input wire logic [`GPU_PIX_BITS-1:0] st1_index,
	input wire logic covered,
	input wire logic closer,
	input pixel_word_u clear_word,
	input pixel_word_u tri_color,
	input wire logic mem_waitrequest,
	output logic mem_write,
	output logic [`GPU_PIX_BITS-1:0] mem_address,
	output logic [31:0] mem_writedata,
	output logic stall,
	output logic commit,
	output logic [`GPU_PIX_BITS-1:0] commit_index
);

	logic waiting;
	logic wr_render;
	logic fresh_write;
	logic [31:0] fresh_data;
	logic [31:0] hold_data;

	always_comb begin
		wr_render = st1_valid && (mode == MODE_RENDER) && covered && closer;
		fresh_write = wr_render || (st1_valid && mode == MODE_CLEAR_FRAME);
		// Pad byte goes out as zero
		if (mode == MODE_RENDER)
			fresh_data = {8'h00, tri_color.color.red, tri_color.color.green,
				tri_color.color.blue};
		else
			fresh_data = {8'h00, clear_word.color.red, clear_word.color.green,
				clear_word.color.blue};
	end

	// A write that met waitrequest stays up with its first word
	assign mem_write = waiting || fresh_write;
	assign mem_writedata = waiting ? hold_data : fresh_data;
	assign mem_address = st1_index;
	assign stall = mem_write && mem_waitrequest;

	assign commit = mem_write && !mem_waitrequest && (mode == MODE_RENDER);
	assign commit_index = st1_index;

	always_ff @(posedge rast_done or negedge rst_n) begin
		if (!rst_n)
			waiting <= 1'b0;
		else
			waiting <= stall;
	end

	always_ff @(posedge rast_done) begin
		if (!waiting)
			hold_data <= fresh_data;
	end

endmodule

`default_nettype wire

//--- src/raster_sequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "gpu_params.svh"

module raster_sequencer (
	input wire logic rast_done,
	input wire logic rst_n,
	input wire logic go,
	input wire logic stall,
	output logic pix_valid,
	output logic [`GPU_COORD_BITS-1:0] pix_x,
	output logic [`GPU_COORD_BITS-1:0] pix_y,
	output logic [`GPU_PIX_BITS-1:0] pix_index,
	output logic st1_valid,
	output logic [`GPU_PIX_BITS-1:0] st1_index,
	output logic finish
);

	localparam logic [`GPU_COORD_BITS-1:0] LAST_X = `GPU_COORD_BITS'(`GPU_SCREEN_W - 1);
	localparam logic [`GPU_COORD_BITS-1:0] LAST_Y = `GPU_COORD_BITS'(`GPU_SCREEN_H - 1);
	localparam logic [`GPU_PIX_BITS-1:0] LAST_INDEX =
		`GPU_PIX_BITS'(`GPU_SCREEN_W * `GPU_SCREEN_H - 1);

	always_ff @(posedge rast_done or negedge rst_n) begin
		if (!rst_n) begin
			pix_valid <= 1'b0;
			pix_x <= '0;
			pix_y <= '0;
			pix_index <= '0;
			st1_valid <= 1'b0;
			st1_index <= '0;
			finish <= 1'b0;
		end else begin
			// Pulse once the final pixel leaves stage 1
			finish <= st1_valid && !stall && (st1_index == LAST_INDEX);

			if (!stall) begin
				st1_valid <= pix_valid;
				st1_index <= pix_index;
			end

			if (go) begin
				pix_valid <= 1'b1;
				pix_x <= '0;
				pix_y <= '0;
				pix_index <= '0;
			end else if (pix_valid && !stall) begin
				pix_index <= pix_index + 1'b1;
				if (pix_x == LAST_X) begin
					pix_x <= '0;
					// Row-major walk ends after the bottom right pixel
					if (pix_y == LAST_Y)
						pix_valid <= 1'b0;
					else
						pix_y <= pix_y + 1'b1;
				end else begin
					pix_x <= pix_x + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- tb.f
+incdir+src
src/gpu_pkg.sv
src/gpu_regs.sv
src/raster_sequencer.sv
src/edge_eval.sv
src/depth_test.sv
src/pixel_writer.sv
src/gpu_core.sv
sim/gpu_chk.sv
sim/gpu_monitor.sv
sim/tb_gpu.sv
